// File: vlog.f
hw/tgen_pkg.sv
hw/tcdm_bank.sv
hw/tcdm_addr_demux.sv
hw/traffic_generator.sv
hw/tgen_subsystem.sv
bench/tgen_asserts.sv
bench/tgen_tb.sv

// File: bench/tgen_tb.sv
/* Testbench for the traffic generator subsystem
   Applies a table of runs and checks done, error count and per-port hits */
`timescale 1ns/1ns

module tgen_tb;
  import tgen_pkg::*;

  typedef struct packed {
    tile_t core_id;
    cnt_t  num_req;
    cnt_t  exp_err;
    logic  mid_reset;
  } row_t;

  localparam int NrRows = 8;

  // core id, requests, expected errors, reset during the run
  localparam row_t Rows [NrRows] = '{
    '{2'd0, 16'd32,  16'd0, 1'b0},
    '{2'd1, 16'd32,  16'd0, 1'b0},
    '{2'd2, 16'd32,  16'd0, 1'b0},
    '{2'd3, 16'd32,  16'd0, 1'b0},
    '{2'd2, 16'd200, 16'd0, 1'b0},
    '{2'd1, 16'd1,   16'd0, 1'b0},
    '{2'd3, 16'd16,  16'd0, 1'b1},
    '{2'd0, 16'd5,   16'd0, 1'b0}
  };

  logic               clk;
  logic               rst_n;
  logic               start;
  tile_t              core_id;
  cnt_t               num_req;
  logic               done;
  cnt_t               err_count;
  cnt_t  [NrTcdm-1:0] port_hits;
  int                 cycle_count;
  int                 cycle_limit;

  tgen_subsystem tgen_subsystem_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .start_i     (start),
    .core_id_i   (core_id),
    .num_req_i   (num_req),
    .done_o      (done),
    .err_count_o (err_count),
    .port_hits_o (port_hits)
  );

  bind tgen_subsystem tgen_asserts tgen_asserts_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid),
    .req_ready_i       (req_ready),
    .resp_valid_i      (resp_valid),
    .bank_req_valid_i  (bank_req_valid),
    .bank_credit_i     (bank_credit),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_i (bank_resp_ready),
    .bank_resp_rdata_i (bank_resp_rdata),
    .bank_resp_id_i    (bank_resp_id)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Each address of the sequence is written once and read once
  function automatic cnt_t hits_for_port(tile_t core, cnt_t n, int port);
    logic [15:0] state;
    tile_t       tile;
    addr_t       addr;
    cnt_t        hits;
    state = LfsrSeedBase ^ {14'd0, core};
    hits  = '0;
    for (int i = 0; i < int'(n); i++) begin
      state = lfsr_step(state);
      tile  = state[15] ? core : state[7:6];
      addr  = TcdmBase + addr_t'(tile) * 16'd256 + addr_t'(state[5:0]) * 16'd4;
      if (int'((addr - TcdmBase) >> 8) == port) hits = hits + 16'd2;
    end
    return hits;
  endfunction

  function automatic int limit_from_table();
    int total;
    total = 0;
    foreach (Rows[r]) total += 20 * int'(Rows[r].num_req) + 100;
    return total;
  endfunction

  task automatic check_cnt(input cnt_t got, input cnt_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_hits_zero(input string when);
    for (int p = 0; p < NrTcdm; p++) begin
      check_cnt(port_hits[p], '0, $sformatf("port_hits_o[%0d] %s", p, when));
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag(done, 1'b0, "done_o after reset");
    check_cnt(err_count, '0, "err_count_o after reset");
    check_hits_zero("after reset");
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic run_row(input row_t row);
    core_id = row.core_id;
    num_req = row.num_req;
    @(posedge clk);
    #1;
    if (row.mid_reset) begin
      // Abort a run part way, then start over cleanly
      pulse_start();
      repeat (10) @(posedge clk);
      #1;
      apply_reset();
    end
    pulse_start();
    check_flag(done, 1'b0, "done_o after start");
    check_hits_zero("after start");
    while (!done) begin
      @(posedge clk);
      #1;
    end
    check_cnt(err_count, row.exp_err, "err_count_o");
    for (int p = 0; p < NrTcdm; p++) begin
      check_cnt(port_hits[p], hits_for_port(row.core_id, row.num_req, p),
                $sformatf("port_hits_o[%0d] for core %0d", p, row.core_id));
    end
    repeat (3) @(posedge clk);
    #1;
    check_flag(done, 1'b1, "done_o held after the run");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: done_o did not rise within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  always @(posedge clk) begin
    if (tgen_subsystem_i.tgen_asserts_i.fail_count != 0) begin
      $display("A bound assertion failed, see the error above");
      $display("Result: FAILED");
      $fatal(1, "Run stopped by a failed assertion");
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    core_id     = '0;
    num_req     = '0;
    cycle_count = 0;
    cycle_limit = limit_from_table();
    apply_reset();
    foreach (Rows[r]) run_row(Rows[r]);
    if (tgen_subsystem_i.tgen_asserts_i.fail_count != 0) begin
      $display("Assertion failures: %0d", tgen_subsystem_i.tgen_asserts_i.fail_count);
      $display("Result: FAILED");
      $fatal(1, "Bound assertions failed");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule : tgen_tb

// File: bench/tgen_asserts.sv
/* Bound checks for the traffic generator subsystem
   Credit range, in-flight limit and held bank responses */
`timescale 1ns/1ns

module tgen_asserts (
  input logic                                    clk_i,
  input logic                                    rst_ni,
  input logic                                    req_valid_i,
  input logic                                    req_ready_i,
  input logic                                    resp_valid_i,
  input logic            [tgen_pkg::NrTcdm-1:0] bank_req_valid_i,
  input logic            [tgen_pkg::NrTcdm-1:0] bank_credit_i,
  input logic            [tgen_pkg::NrTcdm-1:0] bank_resp_valid_i,
  input logic            [tgen_pkg::NrTcdm-1:0] bank_resp_ready_i,
  input tgen_pkg::data_t [tgen_pkg::NrTcdm-1:0] bank_resp_rdata_i,
  input tgen_pkg::id_t   [tgen_pkg::NrTcdm-1:0] bank_resp_id_i
);
  import tgen_pkg::*;

  int fail_count = 0;
  int inflight;
  int credits [NrTcdm];

  // Shadow counts rebuilt from the handshakes alone
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight <= 0;
      for (int p = 0; p < NrTcdm; p++) begin
        credits[p] <= int'(BankCredits);
      end
    end else begin
      inflight <= inflight + int'(req_valid_i && req_ready_i) - int'(resp_valid_i);
      for (int p = 0; p < NrTcdm; p++) begin
        credits[p] <= credits[p] + int'(bank_credit_i[p]) - int'(bank_req_valid_i[p]);
      end
    end
  end

  // A response without a request drives the count below zero
  inflight_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inflight >= 0 && inflight <= int'(MaxOutstanding))
    else begin
      $error("In-flight count %0d outside 0 to %0d", inflight, MaxOutstanding);
      fail_count++;
    end

  for (genvar p = 0; p < NrTcdm; p++) begin : gen_port
    credit_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      credits[p] >= 0 && credits[p] <= int'(BankCredits))
      else begin
        $error("Credit count of port %0d out of range: %0d", p, credits[p]);
        fail_count++;
      end

    // Waiting response must not change until granted
    resp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_resp_valid_i[p] && !bank_resp_ready_i[p] |=> bank_resp_valid_i[p]
      && $stable(bank_resp_rdata_i[p]) && $stable(bank_resp_id_i[p]))
      else begin
        $error("Held response of bank %0d changed before grant", p);
        fail_count++;
      end
  end

endmodule : tgen_asserts

// File: hw/tgen_subsystem.sv
/* Traffic generator subsystem with one generator, the address demux and four banks */
`timescale 1ns/1ns

module tgen_subsystem (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   start_i,
  input  tgen_pkg::tile_t                        core_id_i,
  input  tgen_pkg::cnt_t                         num_req_i,
  output logic                                   done_o,
  output tgen_pkg::cnt_t                         err_count_o,
  output tgen_pkg::cnt_t [tgen_pkg::NrTcdm-1:0] port_hits_o
);
  import tgen_pkg::*;

  // Generator to demux
  logic  req_valid, req_wen, req_ready, resp_valid;
  addr_t req_addr;
  data_t req_wdata, resp_rdata;
  id_t   req_id, resp_id;

  // Demux to banks
  logic  [NrTcdm-1:0] bank_req_valid, bank_req_wen, bank_credit;
  logic  [NrTcdm-1:0] bank_resp_valid, bank_resp_ready;
  addr_t [NrTcdm-1:0] bank_req_addr;
  data_t [NrTcdm-1:0] bank_req_wdata, bank_resp_rdata;
  id_t   [NrTcdm-1:0] bank_req_id, bank_resp_id;

  traffic_generator i_tgen (
    .clk_i, .rst_ni, .start_i, .core_id_i, .num_req_i,
    .req_valid_o  (req_valid),
    .req_addr_o   (req_addr),
    .req_wen_o    (req_wen),
    .req_wdata_o  (req_wdata),
    .req_id_o     (req_id),
    .req_ready_i  (req_ready),
    .resp_valid_i (resp_valid),
    .resp_rdata_i (resp_rdata),
    .resp_id_i    (resp_id),
    .done_o, .err_count_o
  );

  tcdm_addr_demux i_demux (
    .clk_i, .rst_ni, .start_i,
    .req_valid_i  (req_valid),
    .req_addr_i   (req_addr),
    .req_wen_i    (req_wen),
    .req_wdata_i  (req_wdata),
    .req_id_i     (req_id),
    .req_ready_o  (req_ready),
    .resp_valid_o (resp_valid),
    .resp_rdata_o (resp_rdata),
    .resp_id_o    (resp_id),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_addr_o   (bank_req_addr),
    .bank_req_wen_o    (bank_req_wen),
    .bank_req_wdata_o  (bank_req_wdata),
    .bank_req_id_o     (bank_req_id),
    .bank_credit_i     (bank_credit),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_rdata_i (bank_resp_rdata),
    .bank_resp_id_i    (bank_resp_id),
    .bank_resp_ready_o (bank_resp_ready),
    .port_hits_o
  );

  for (genvar p = 0; p < NrTcdm; p++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i, .rst_ni,
      .req_valid_i  (bank_req_valid[p]),
      .req_addr_i   (bank_req_addr[p]),
      .req_wen_i    (bank_req_wen[p]),
      .req_wdata_i  (bank_req_wdata[p]),
      .req_id_i     (bank_req_id[p]),
      .credit_o     (bank_credit[p]),
      .resp_valid_o (bank_resp_valid[p]),
      .resp_rdata_o (bank_resp_rdata[p]),
      .resp_id_o    (bank_resp_id[p]),
      .resp_ready_i (bank_resp_ready[p])
    );
  end

endmodule : tgen_subsystem

// File: hw/traffic_generator.sv
/* Traffic generator standing in for one core
   Writes an LFSR address sequence, then reads it back and checks the data */
`timescale 1ns/1ns

module traffic_generator (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  tgen_pkg::tile_t core_id_i,
  input  tgen_pkg::cnt_t  num_req_i,
  output logic            req_valid_o,
  output tgen_pkg::addr_t req_addr_o,
  output logic            req_wen_o,
  output tgen_pkg::data_t req_wdata_o,
  output tgen_pkg::id_t   req_id_o,
  input  logic            req_ready_i,
  input  logic            resp_valid_i,
  input  tgen_pkg::data_t resp_rdata_i,
  input  tgen_pkg::id_t   resp_id_i,
  output logic            done_o,
  output tgen_pkg::cnt_t  err_count_o
);
  import tgen_pkg::*;

  gen_state_e state_q;

  logic [15:0] lfsr_q;
  logic [15:0] lfsr_next;
  logic [15:0] lfsr_seed;
  tile_t       tgt_tile;

  cnt_t                     issued_q;
  logic [InflightWidth-1:0] inflight_q;
  logic [MaxOutstanding-1:0] slot_busy_q;
  logic [MaxOutstanding-1:0] slot_busy_d;
  addr_t                    slot_addr_q [MaxOutstanding];
  id_t                      free_id;
  cnt_t                     err_q;

  logic issue_phase;
  logic check_phase;
  logic req_fire;
  logic rd_mismatch;

  // Fibonacci LFSR with taps 16 14 13 11
  assign lfsr_next = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
  assign lfsr_seed = LfsrSeedBase ^ 16'(core_id_i);

  // Bit 15 picks the own tile, else bits 7:6 name the remote one
  assign tgt_tile   = lfsr_next[15] ? core_id_i : lfsr_next[7:6];
  assign req_addr_o = PortBase[tgt_tile] + (addr_t'(lfsr_next[BankWordBits-1:0]) << ByteOffset);

  assign issue_phase = (state_q == GenWrite) || (state_q == GenRead);
  assign check_phase = (state_q == GenRead) || (state_q == GenDrainR);

  assign req_valid_o = issue_phase && (issued_q < num_req_i) && (inflight_q < MaxOutstanding);
  assign req_wen_o   = (state_q == GenWrite);
  assign req_wdata_o = data_t'(req_addr_o);
  assign req_id_o    = free_id;
  assign req_fire    = req_valid_o && req_ready_i;

  assign rd_mismatch = resp_rdata_i != data_t'(slot_addr_q[resp_id_i]);

  // Lowest free slot becomes the next ID
  always_comb begin
    free_id = '0;
    for (int i = MaxOutstanding - 1; i >= 0; i--) begin
      if (!slot_busy_q[i]) free_id = id_t'(i);
    end
  end

  always_comb begin
    slot_busy_d = slot_busy_q;
    if (resp_valid_i) slot_busy_d[resp_id_i] = 1'b0;
    if (req_fire) slot_busy_d[free_id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= GenIdle;
      lfsr_q      <= LfsrSeedBase;
      issued_q    <= '0;
      inflight_q  <= '0;
      slot_busy_q <= '0;
      err_q       <= '0;
    end else begin
      inflight_q  <= inflight_q + InflightWidth'(req_fire) - InflightWidth'(resp_valid_i);
      slot_busy_q <= slot_busy_d;
      if (resp_valid_i && check_phase && rd_mismatch) err_q <= err_q + cnt_t'(1);
      case (state_q)
        GenIdle, GenDone: begin
          if (start_i) begin
            state_q  <= GenWrite;
            lfsr_q   <= lfsr_seed;
            issued_q <= '0;
            err_q    <= '0;
          end
        end
        GenWrite, GenRead: begin
          if (req_fire) begin
            lfsr_q   <= lfsr_next;
            issued_q <= issued_q + cnt_t'(1);
          end else if (issued_q >= num_req_i) begin
            state_q <= (state_q == GenWrite) ? GenDrainW : GenDrainR;
          end
        end
        GenDrainW: begin
          // Replay the same sequence as reads
          if (inflight_q == '0) begin
            state_q  <= GenRead;
            lfsr_q   <= lfsr_seed;
            issued_q <= '0;
          end
        end
        GenDrainR: begin
          if (inflight_q == '0) state_q <= GenDone;
        end
        default: state_q <= GenIdle;
      endcase
    end
  end

  // Expected read data per slot
  always_ff @(posedge clk_i) begin
    if (req_fire) slot_addr_q[free_id] <= req_addr_o;
  end

  assign done_o      = (state_q == GenDone);
  assign err_count_o = err_q;

endmodule : traffic_generator

// File: hw/tcdm_addr_demux.sv
/* Address demultiplexer between the generator and the tile banks
   Credit-based request routing, per-port hit counts, round-robin responses */
`timescale 1ns/1ns

module tcdm_addr_demux (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    start_i,
  // Generator side
  input  logic                                    req_valid_i,
  input  tgen_pkg::addr_t                         req_addr_i,
  input  logic                                    req_wen_i,
  input  tgen_pkg::data_t                         req_wdata_i,
  input  tgen_pkg::id_t                           req_id_i,
  output logic                                    req_ready_o,
  output logic                                    resp_valid_o,
  output tgen_pkg::data_t                         resp_rdata_o,
  output tgen_pkg::id_t                           resp_id_o,
  // Bank side
  output logic            [tgen_pkg::NrTcdm-1:0] bank_req_valid_o,
  output tgen_pkg::addr_t [tgen_pkg::NrTcdm-1:0] bank_req_addr_o,
  output logic            [tgen_pkg::NrTcdm-1:0] bank_req_wen_o,
  output tgen_pkg::data_t [tgen_pkg::NrTcdm-1:0] bank_req_wdata_o,
  output tgen_pkg::id_t   [tgen_pkg::NrTcdm-1:0] bank_req_id_o,
  input  logic            [tgen_pkg::NrTcdm-1:0] bank_credit_i,
  input  logic            [tgen_pkg::NrTcdm-1:0] bank_resp_valid_i,
  input  tgen_pkg::data_t [tgen_pkg::NrTcdm-1:0] bank_resp_rdata_i,
  input  tgen_pkg::id_t   [tgen_pkg::NrTcdm-1:0] bank_resp_id_i,
  output logic            [tgen_pkg::NrTcdm-1:0] bank_resp_ready_o,
  output tgen_pkg::cnt_t  [tgen_pkg::NrTcdm-1:0] port_hits_o
);
  import tgen_pkg::*;

  logic [NrTcdm-1:0]      port_sel;
  logic [NrTcdm-1:0]      has_credit;
  logic [CreditWidth-1:0] credit_q [NrTcdm];
  cnt_t                   hits_q   [NrTcdm];

  tile_t rr_q;
  tile_t gnt_idx;
  logic  gnt_found;

  // Decode and credit gating
  always_comb begin
    for (int p = 0; p < NrTcdm; p++) begin
      port_sel[p]   = (req_addr_i >= PortBase[p]) && (req_addr_i < PortBase[p] + PortSpan);
      has_credit[p] = credit_q[p] != '0;
      bank_req_valid_o[p] = req_valid_i && port_sel[p] && has_credit[p];
      bank_req_addr_o[p]  = req_addr_i;
      bank_req_wen_o[p]   = req_wen_i;
      bank_req_wdata_o[p] = req_wdata_i;
      bank_req_id_o[p]    = req_id_i;
      port_hits_o[p]      = hits_q[p];
    end
    req_ready_o = |(port_sel & has_credit);
  end

  // A credit is spent on send and returned on the bank's pop pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int p = 0; p < NrTcdm; p++) begin
        credit_q[p] <= CreditWidth'(BankCredits);
        hits_q[p]   <= '0;
      end
    end else begin
      for (int p = 0; p < NrTcdm; p++) begin
        credit_q[p] <= credit_q[p] + CreditWidth'(bank_credit_i[p])
                       - CreditWidth'(bank_req_valid_o[p]);
        if (start_i) begin
          hits_q[p] <= '0;
        end else if (bank_req_valid_o[p]) begin
          hits_q[p] <= hits_q[p] + cnt_t'(1);
        end
      end
    end
  end

  // Round robin search starting at rr_q
  always_comb begin : arb
    tile_t cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int k = 0; k < NrTcdm; k++) begin
      cand = rr_q + tile_t'(k);
      if (!gnt_found && bank_resp_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
    resp_valid_o      = gnt_found;
    resp_rdata_o      = bank_resp_rdata_i[gnt_idx];
    resp_id_o         = bank_resp_id_i[gnt_idx];
    bank_resp_ready_o = '0;
    if (gnt_found) bank_resp_ready_o[gnt_idx] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (gnt_found) begin
      rr_q <= gnt_idx + tile_t'(1);
    end
  end

endmodule : tcdm_addr_demux

// File: hw/tcdm_bank.sv
/* Tile memory bank with a request queue and a held response register
   Each pop returns a credit and answers one cycle later */
`timescale 1ns/1ns

module tcdm_bank (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  input  tgen_pkg::addr_t req_addr_i,
  input  logic            req_wen_i,
  input  tgen_pkg::data_t req_wdata_i,
  input  tgen_pkg::id_t   req_id_i,
  output logic            credit_o,
  output logic            resp_valid_o,
  output tgen_pkg::data_t resp_rdata_o,
  output tgen_pkg::id_t   resp_id_o,
  input  logic            resp_ready_i
);
  import tgen_pkg::*;

  // Request queue
  word_idx_t q_idx   [BankCredits];
  logic      q_wen   [BankCredits];
  data_t     q_wdata [BankCredits];
  id_t       q_id    [BankCredits];

  logic [$clog2(BankCredits)-1:0] wr_ptr_q;
  logic [$clog2(BankCredits)-1:0] rd_ptr_q;
  logic [CreditWidth-1:0]         count_q;

  data_t     mem_q [2**BankWordBits];
  word_idx_t pop_idx;
  logic      pop;

  // Pop only when the response slot is free or being taken this cycle
  assign pop      = (count_q != '0) && (!resp_valid_o || resp_ready_i);
  assign credit_o = pop;
  assign pop_idx  = q_idx[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      if (req_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CreditWidth'(req_valid_i) - CreditWidth'(pop);
      if (pop) begin
        resp_valid_o <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_o <= 1'b0;
      end
    end
  end

  // Queue storage, SRAM and response payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      q_idx[wr_ptr_q]   <= req_addr_i[ByteOffset +: BankWordBits];
      q_wen[wr_ptr_q]   <= req_wen_i;
      q_wdata[wr_ptr_q] <= req_wdata_i;
      q_id[wr_ptr_q]    <= req_id_i;
    end
    if (pop) begin
      if (q_wen[rd_ptr_q]) begin
        mem_q[pop_idx] <= q_wdata[rd_ptr_q];
        resp_rdata_o   <= q_wdata[rd_ptr_q];
      end else begin
        resp_rdata_o <= mem_q[pop_idx];
      end
      resp_id_o <= q_id[rd_ptr_q];
    end
  end

endmodule : tcdm_bank

// File: hw/tgen_pkg.sv
/* Shared definitions for the TCDM traffic generator subsystem
   Address layout, widths, credit depth, address map and generator states */
package tgen_pkg;

  // Tile ports and address layout
  localparam int unsigned NrTcdm       = 4;
  localparam int unsigned ByteOffset   = 2;
  localparam int unsigned BankWordBits = 6;
  localparam int unsigned TileBits     = 2;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 3;

  // In-flight limit with one slot per request ID
  localparam int unsigned MaxOutstanding = 8;
  localparam int unsigned InflightWidth  = $clog2(MaxOutstanding + 1);

  // Each bank queue is this deep, so this is also the initial credit count
  localparam int unsigned BankCredits = 4;
  localparam int unsigned CreditWidth = $clog2(BankCredits + 1);

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [15:0]             cnt_t;
  typedef logic [TileBits-1:0]     tile_t;
  typedef logic [BankWordBits-1:0] word_idx_t;

  localparam addr_t TcdmBase = 16'h1000;

  // Bytes covered by one tile port
  localparam addr_t PortSpan = 16'h0100;

  // Fixed address map where port p starts at TcdmBase + p * PortSpan
  localparam addr_t PortBase [NrTcdm] = '{
    addr_t'(TcdmBase),
    addr_t'(TcdmBase + PortSpan),
    addr_t'(TcdmBase + 2 * PortSpan),
    addr_t'(TcdmBase + 3 * PortSpan)
  };

  // XORed with the core id to get the per-core seed
  localparam logic [15:0] LfsrSeedBase = 16'hACE1;

  typedef enum logic [2:0] {
    GenIdle,
    GenWrite,
    GenDrainW,
    GenRead,
    GenDrainR,
    GenDone
  } gen_state_e;

endpackage : tgen_pkg
